// File: rtl/vec_csr_pkg.sv
`default_nettype none

package vec_csr_pkg;

    ////////////////////////////////////////
    // widths and encodings
    ////////////////////////////////////////

    localparam int XLEN = 32;
    localparam int VLEN = 512;              // bits per vector register
    localparam int VL_W = 10;               // holds vlmax up to 512

    localparam logic [6:0] OPC_SYSTEM = 7'h73;
    localparam int VTYPE_ILL_BIT = XLEN - 1;

    // vector csr addresses
    typedef enum logic [11:0] {
        CSR_VSTART = 12'h008,
        CSR_VL     = 12'hC20,
        CSR_VTYPE  = 12'hC21
    } csr_reg_e;

    // zicsr funct3
    typedef enum logic [2:0] {
        CSR_RW  = 3'b001,
        CSR_RS  = 3'b010,
        CSR_RC  = 3'b011,
        CSR_RWI = 3'b101,
        CSR_RSI = 3'b110,
        CSR_RCI = 3'b111
    } csr_op_e;

    typedef enum logic [2:0] {
        LMUL_1    = 3'd0,
        LMUL_2    = 3'd1,
        LMUL_4    = 3'd2,
        LMUL_8    = 3'd3,
        LMUL_RSVD = 3'd4   // fractional encodings land here too
    } vlmul_e;

    typedef enum logic [2:0] {
        EW8    = 3'd0,
        EW16   = 3'd1,
        EW32   = 3'd2,
        EW64   = 3'd3,
        EWRSVD = 3'd4
    } vew_e;

    // width field of vector loads and stores
    typedef enum logic [2:0] {
        MW8  = 3'd0,
        MW16 = 3'd5,
        MW32 = 3'd6,
        MW64 = 3'd7
    } mem_width_e;

    typedef struct packed {
        logic   ill;
        logic   vma;
        logic   vta;
        vew_e   vsew;
        vlmul_e vlmul;
    } csr_vtype_s;

    // numeric lmul, reserved reads as 1
    function automatic logic [3:0] lmul_to_num(vlmul_e lmul);
        case (lmul)
            LMUL_2:  return 4'd2;
            LMUL_4:  return 4'd4;
            LMUL_8:  return 4'd8;
            default: return 4'd1;
        endcase
    endfunction

    // numeric sew, reserved reads as 32
    function automatic logic [6:0] sew_to_num(vew_e vsew);
        case (vsew)
            EW8:     return 7'd8;
            EW16:    return 7'd16;
            EW64:    return 7'd64;
            default: return 7'd32;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: rtl/vec_config_unit.sv
`timescale 1ns/10ps
`default_nettype none

module vec_config_unit (
    input  wire                                 clk,
    input  wire                                 n_rst,
    input  wire        [vec_csr_pkg::XLEN-1:0]  inst,
    input  wire        [vec_csr_pkg::XLEN-1:0]  scalar1,    // requested avl
    input  wire        [vec_csr_pkg::XLEN-1:0]  scalar2,    // new vtype bits
    input  wire                                 avl_valid,
    input  wire                                 vset_en,
    output vec_csr_pkg::csr_vtype_s             vtype,
    output logic       [vec_csr_pkg::XLEN-1:0]  vl,
    output logic       [vec_csr_pkg::VL_W-1:0]  vlmax,
    output logic                                done
);
    import vec_csr_pkg::*;

    logic            vset_prev;     // vset_en at the previous edge
    logic            wr_en;
    logic            keep_vl;
    vlmul_e          new_lmul;
    vew_e            new_sew;
    logic [VL_W-1:0] vlmax_d;
    logic [XLEN-1:0] vl_d;

    ////////////////////////////////////////
    // strobe edge detect
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vset_prev <= 1'b0;
        end else if (done) begin
            vset_prev <= 1'b0;
        end else begin
            vset_prev <= vset_en;
        end
    end

    assign wr_en = vset_en && !vset_prev;

    ////////////////////////////////////////
    // next vlmax and vl
    ////////////////////////////////////////

    assign new_lmul = vlmul_e'(scalar2[2:0]);
    assign new_sew  = vew_e'(scalar2[5:3]);

    // rs1 = x0 and rd = x0 keeps the current vl
    assign keep_vl = (inst[19:15] == 5'd0) && (inst[11:7] == 5'd0);

    always_comb begin
        vlmax_d = VL_W'((VLEN / int'(sew_to_num(new_sew))) * int'(lmul_to_num(new_lmul)));
    end

    always_comb begin
        if (keep_vl) begin
            vl_d = vl;
        end else if (avl_valid) begin
            vl_d = (scalar1 > XLEN'(vlmax_d)) ? XLEN'(vlmax_d) : scalar1;   // min(avl, vlmax)
        end else begin
            vl_d = XLEN'(vlmax_d);
        end
    end

    ////////////////////////////////////////
    // vtype, vl, vlmax registers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vtype <= '{ill: 1'b1, vma: 1'b0, vta: 1'b0, vsew: EW8, vlmul: LMUL_1};
            vl    <= '0;
            vlmax <= '0;
            done  <= 1'b0;
        end else if (wr_en) begin
            vtype <= '{ill: 1'b0, vma: scalar2[7], vta: scalar2[6],
                       vsew: new_sew, vlmul: new_lmul};
            vl    <= vl_d;
            vlmax <= vlmax_d;
            done  <= 1'b1;      // single pulse next cycle
        end else begin
            done  <= 1'b0;
        end
    end

    // one write per strobe rise, so done never stretches
    assert property (@(posedge clk) disable iff (!n_rst) done |=> !done)
        else $error("done high on two consecutive cycles");

    // a write that sets vl leaves it within the new vlmax
    assert property (@(posedge clk) disable iff (!n_rst)
        (wr_en && !keep_vl) |=> (vl <= XLEN'(vlmax)))
        else $error("vl above vlmax after write");

endmodule

`default_nettype wire

// File: rtl/vstart_csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module vstart_csr_unit (
    input  wire                                clk,
    input  wire                                n_rst,
    input  wire       [vec_csr_pkg::XLEN-1:0]  inst,
    input  wire       [vec_csr_pkg::XLEN-1:0]  scalar1,    // rs1 value or zext uimm
    output logic      [vec_csr_pkg::XLEN-1:0]  vstart,
    output vec_csr_pkg::csr_reg_e              read_sel,
    output logic                               read_en,
    output logic                               access_ok
);
    import vec_csr_pkg::*;

    logic [6:0]      opcode;
    logic [4:0]      rs1_addr;
    csr_op_e         funct3;
    csr_reg_e        csr_addr;
    logic            is_system;
    logic            op_known;
    logic            is_vstart;
    logic            is_ro;         // vl or vtype
    logic            ro_write;
    logic            vstart_wr;
    logic [XLEN-1:0] vstart_d;

    ////////////////////////////////////////
    // zicsr field decode
    ////////////////////////////////////////

    assign opcode   = inst[6:0];
    assign funct3   = csr_op_e'(inst[14:12]);
    assign rs1_addr = inst[19:15];
    assign csr_addr = csr_reg_e'(inst[31:20]);

    assign is_system = (opcode == OPC_SYSTEM);
    assign op_known  = funct3 inside {CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};
    assign is_vstart = (csr_addr == CSR_VSTART);
    assign is_ro     = csr_addr inside {CSR_VL, CSR_VTYPE};

    // rw forms always write, set/clear only with a nonzero rs1 field
    assign ro_write = (funct3 inside {CSR_RW, CSR_RWI}) || (rs1_addr != 5'd0);

    // non-system opcodes are not ours to judge
    assign access_ok = !is_system || (op_known && (is_vstart || (is_ro && !ro_write)));

    assign read_en  = is_system && access_ok;
    assign read_sel = csr_addr;

    ////////////////////////////////////////
    // vstart read-modify-write
    ////////////////////////////////////////

    assign vstart_wr = is_system && op_known && is_vstart;

    always_comb begin
        case (funct3)
            CSR_RW, CSR_RWI: vstart_d = scalar1;
            CSR_RS, CSR_RSI: vstart_d = vstart | scalar1;
            CSR_RC, CSR_RCI: vstart_d = vstart & ~scalar1;
            default:         vstart_d = vstart;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vstart <= '0;
        end else if (vstart_wr) begin
            vstart <= vstart_d;
        end
    end

    // holds across idle and non-system cycles
    assert property (@(posedge clk) disable iff (!n_rst)
        !$stable(vstart) |-> $past(is_system))
        else $error("vstart changed without a system instruction");

endmodule

`default_nettype wire

// File: rtl/vec_csr_read_port.sv
`timescale 1ns/10ps
`default_nettype none

module vec_csr_read_port (
    input  wire  vec_csr_pkg::csr_vtype_s           vtype,
    input  wire        [vec_csr_pkg::XLEN-1:0]      vl,
    input  wire        [vec_csr_pkg::XLEN-1:0]      vstart,
    input  wire  vec_csr_pkg::csr_reg_e             read_sel,
    input  wire                                     read_en,
    input  wire                                     access_ok,
    output logic       [vec_csr_pkg::XLEN-1:0]      csr_out,
    output logic                                    illegal_insn
);
    import vec_csr_pkg::*;

    logic [XLEN-1:0] vtype_word;

    ////////////////////////////////////////
    // vtype as an xlen csr
    ////////////////////////////////////////

    // ill sits at the msb, the rest packs into the low byte
    always_comb begin
        vtype_word                = '0;
        vtype_word[VTYPE_ILL_BIT] = vtype.ill;
        vtype_word[7]             = vtype.vma;
        vtype_word[6]             = vtype.vta;
        vtype_word[5:3]           = vtype.vsew;
        vtype_word[2:0]           = vtype.vlmul;
    end

    ////////////////////////////////////////
    // read select
    ////////////////////////////////////////

    // old register values, same cycle as the access
    always_comb begin
        csr_out = '0;
        if (read_en) begin
            case (read_sel)
                CSR_VSTART: csr_out = vstart;
                CSR_VL:     csr_out = vl;
                CSR_VTYPE:  csr_out = vtype_word;
                default:    csr_out = '0;
            endcase
        end
    end

    assign illegal_insn = !access_ok;

endmodule

`default_nettype wire

// File: rtl/vec_mem_width_decode.sv
`timescale 1ns/10ps
`default_nettype none

module vec_mem_width_decode (
    input  wire  vec_csr_pkg::csr_vtype_s       vtype,
    input  wire  vec_csr_pkg::mem_width_e       width,
    output logic       [3:0]                    vlmul,
    output logic       [6:0]                    sew,
    output logic       [6:0]                    eew,
    output logic       [3:0]                    emul,
    output logic       [vec_csr_pkg::VL_W-1:0]  e_vlmax
);
    import vec_csr_pkg::*;

    logic [9:0] eew_lmul;       // eew * lmul up to 512
    logic [9:0] sew_max;        // sew * 8 bounds emul from above

    ////////////////////////////////////////
    // vtype decode
    ////////////////////////////////////////

    always_comb begin
        vlmul = lmul_to_num(vtype.vlmul);
        sew   = sew_to_num(vtype.vsew);
    end

    ////////////////////////////////////////
    // eew, emul, e_vlmax
    ////////////////////////////////////////

    always_comb begin
        case (width)
            MW8:     eew = 7'd8;
            MW16:    eew = 7'd16;
            MW32:    eew = 7'd32;
            MW64:    eew = 7'd64;
            default: eew = 7'd32;   // reserved width
        endcase

        // emul = eew * lmul / sew with its range checked before dividing
        eew_lmul = 10'(eew) * 10'(vlmul);
        sew_max  = 10'(sew) << 3;

        if ((eew_lmul < 10'(sew)) || (eew_lmul > sew_max)) begin
            emul = 4'd1;            // fractional or above 8
        end else begin
            emul = 4'(eew_lmul / 10'(sew));
        end

        e_vlmax = VL_W'((VLEN / int'(eew)) * int'(emul));
    end

    // clamp leaves only the power of two group sizes
    always_comb begin
        assert (emul inside {4'd1, 4'd2, 4'd4, 4'd8})
            else $error("emul out of range: %0d", emul);
    end

endmodule

`default_nettype wire

// File: rtl/vec_csr_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module vec_csr_regfile (
    input  wire                                clk,
    input  wire                                n_rst,
    input  wire       [vec_csr_pkg::XLEN-1:0]  inst,
    input  wire       [vec_csr_pkg::XLEN-1:0]  scalar1,
    input  wire       [vec_csr_pkg::XLEN-1:0]  scalar2,
    input  wire                                avl_valid,
    input  wire                                vset_en,
    input  wire  vec_csr_pkg::mem_width_e      width,
    output logic      [vec_csr_pkg::XLEN-1:0]  csr_out,
    output logic                               illegal_insn,
    output logic      [3:0]                    vlmul,
    output logic      [6:0]                    sew,
    output logic      [vec_csr_pkg::VL_W-1:0]  vlmax,
    output logic      [3:0]                    emul,
    output logic      [6:0]                    eew,
    output logic      [vec_csr_pkg::VL_W-1:0]  e_vlmax,
    output logic                               tail_agnostic,
    output logic                               mask_agnostic,
    output logic      [vec_csr_pkg::XLEN-1:0]  vec_length,
    output logic      [vec_csr_pkg::XLEN-1:0]  start_element,
    output logic                               csr_done
);
    import vec_csr_pkg::*;

    csr_vtype_s      vtype_q;
    logic [XLEN-1:0] vl_q;
    logic [XLEN-1:0] vstart_q;
    csr_reg_e        read_sel;
    logic            read_en;
    logic            access_ok;

    ////////////////////////////////////////
    // units
    ////////////////////////////////////////

    vec_config_unit u_config (
        .clk       (clk),
        .n_rst     (n_rst),
        .inst      (inst),
        .scalar1   (scalar1),
        .scalar2   (scalar2),
        .avl_valid (avl_valid),
        .vset_en   (vset_en),
        .vtype     (vtype_q),
        .vl        (vl_q),
        .vlmax     (vlmax),
        .done      (csr_done)
    );

    vstart_csr_unit u_vstart (
        .clk       (clk),
        .n_rst     (n_rst),
        .inst      (inst),
        .scalar1   (scalar1),
        .vstart    (vstart_q),
        .read_sel  (read_sel),
        .read_en   (read_en),
        .access_ok (access_ok)
    );

    vec_csr_read_port u_read_port (
        .vtype        (vtype_q),
        .vl           (vl_q),
        .vstart       (vstart_q),
        .read_sel     (read_sel),
        .read_en      (read_en),
        .access_ok    (access_ok),
        .csr_out      (csr_out),
        .illegal_insn (illegal_insn)
    );

    vec_mem_width_decode u_width_dec (
        .vtype   (vtype_q),
        .width   (width),
        .vlmul   (vlmul),
        .sew     (sew),
        .eew     (eew),
        .emul    (emul),
        .e_vlmax (e_vlmax)
    );

    assign tail_agnostic = vtype_q.vta;
    assign mask_agnostic = vtype_q.vma;
    assign vec_length    = vl_q;
    assign start_element = vstart_q;

endmodule

`default_nettype wire

// File: tb/vec_csr_regfile_tb.sv
`timescale 1ns/10ps
`default_nettype none

module vec_csr_regfile_tb;
    import vec_csr_pkg::*;

    localparam int DONE_TIMEOUT = 20;       // cycles to wait for csr_done

    logic            clk = 1'b0;
    logic            n_rst;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] scalar1;
    logic [XLEN-1:0] scalar2;
    logic            avl_valid;
    logic            vset_en;
    mem_width_e      width;

    wire [XLEN-1:0]  csr_out;
    wire             illegal_insn;
    wire [3:0]       vlmul;
    wire [6:0]       sew;
    wire [VL_W-1:0]  vlmax;
    wire [3:0]       emul;
    wire [6:0]       eew;
    wire [VL_W-1:0]  e_vlmax;
    wire             tail_agnostic;
    wire             mask_agnostic;
    wire [XLEN-1:0]  vec_length;
    wire [XLEN-1:0]  start_element;
    wire             csr_done;

    // one line of the case file
    logic [8*160-1:0] line;
    logic [63:0]      kind;
    logic [31:0]      c_inst;
    logic [31:0]      c_s1;
    logic [31:0]      c_s2;
    logic [31:0]      c_avl;
    logic [31:0]      c_width;
    logic [31:0]      exp0;
    logic [31:0]      exp1;
    logic [31:0]      exp2;
    logic [31:0]      exp3;
    logic [31:0]      exp4;

    int          fd;
    int          case_num;
    int          case_errors;
    int          n_pass;
    int          n_fail;
    logic [31:0] lfsr_state = 32'h1514_300a;

    vec_csr_regfile dut (
        .clk           (clk),
        .n_rst         (n_rst),
        .inst          (inst),
        .scalar1       (scalar1),
        .scalar2       (scalar2),
        .avl_valid     (avl_valid),
        .vset_en       (vset_en),
        .width         (width),
        .csr_out       (csr_out),
        .illegal_insn  (illegal_insn),
        .vlmul         (vlmul),
        .sew           (sew),
        .vlmax         (vlmax),
        .emul          (emul),
        .eew           (eew),
        .e_vlmax       (e_vlmax),
        .tail_agnostic (tail_agnostic),
        .mask_agnostic (mask_agnostic),
        .vec_length    (vec_length),
        .start_element (start_element),
        .csr_done      (csr_done)
    );

    always #20 clk = ~clk;                  // 40 ns period

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int n, output logic [31:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic compare_hex(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch case %0d %s: got 0x%h expected 0x%h",
                     case_num, name, got, expected);
            case_errors++;
        end
    endtask

    task automatic set_idle();
        inst      <= '0;
        scalar1   <= '0;
        scalar2   <= '0;
        avl_valid <= 1'b0;
        vset_en   <= 1'b0;
    endtask

    task automatic apply_case_inputs();
        inst      <= c_inst;
        scalar1   <= c_s1;
        scalar2   <= c_s2;
        avl_valid <= c_avl[0];
        width     <= mem_width_e'(c_width[2:0]);
    endtask

    task automatic idle_gap();
        logic [31:0] gap;
        random_bits(2, gap);               // 0 to 3 idle cycles
        repeat (gap) @(posedge clk);
    endtask

    task automatic finish_case(input string kind_name);
        if (case_errors == 0) begin
            n_pass++;
            $display("case %0d %s ok", case_num, kind_name);
        end else begin
            n_fail++;
            $display("case %0d %s failed with %0d errors", case_num, kind_name, case_errors);
        end
    endtask

    ////////////////////////////////////////
    // case kinds
    ////////////////////////////////////////

    task automatic run_vset();
        int waited;
        @(posedge clk);
        apply_case_inputs();
        vset_en <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!csr_done && waited < DONE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!csr_done) begin
            $display("case %0d: csr_done never came after vset_en rose", case_num);
            case_errors++;
        end else begin
            compare_hex("vlmax", 32'(vlmax), exp0);
            compare_hex("vec_length", vec_length, exp1);
            compare_hex("tail_agnostic", 32'(tail_agnostic), exp2);
            compare_hex("mask_agnostic", 32'(mask_agnostic), exp3);
        end
        @(posedge clk);
        set_idle();
        @(negedge clk);
        if (csr_done) begin
            $display("case %0d: csr_done stayed high for a second cycle", case_num);
            case_errors++;
        end
    endtask

    // read value is the old one, vstart moves at the edge
    task automatic run_csr();
        @(posedge clk);
        apply_case_inputs();
        @(negedge clk);
        compare_hex("csr_out", csr_out, exp0);
        compare_hex("illegal_insn", 32'(illegal_insn), exp1);
        @(posedge clk);
        set_idle();
        @(negedge clk);
        compare_hex("start_element", start_element, exp2);
    endtask

    task automatic run_width();
        @(posedge clk);
        apply_case_inputs();
        @(negedge clk);
        compare_hex("vlmul", 32'(vlmul), exp0);
        compare_hex("sew", 32'(sew), exp1);
        compare_hex("eew", 32'(eew), exp2);
        compare_hex("emul", 32'(emul), exp3);
        compare_hex("e_vlmax", 32'(e_vlmax), exp4);
        @(posedge clk);
        set_idle();
    endtask

    task automatic run_cases();
        int got;
        int fields;
        while (!$feof(fd)) begin
            line = '0;
            got  = $fgets(line, fd);
            fields = (got > 0) ? $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", kind,
                                         c_inst, c_s1, c_s2, c_avl, c_width,
                                         exp0, exp1, exp2, exp3, exp4) : 0;
            if (fields == 11) begin         // comment and blank lines fall through
                idle_gap();
                case_num++;
                case_errors = 0;
                if (kind == 64'("VSET")) begin
                    run_vset();
                    finish_case("VSET");
                end else if (kind == 64'("CSR")) begin
                    run_csr();
                    finish_case("CSR");
                end else if (kind == 64'("WIDTH")) begin
                    run_width();
                    finish_case("WIDTH");
                end else begin
                    $display("case %0d: unknown case kind in the case file", case_num);
                    case_errors++;
                    finish_case("unknown");
                end
            end
        end
        if (case_num == 0) begin
            $display("no cases were read from the case file");
            n_fail++;
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        n_rst       <= 1'b0;
        inst        <= '0;
        scalar1     <= '0;
        scalar2     <= '0;
        avl_valid   <= 1'b0;
        vset_en     <= 1'b0;
        width       <= MW8;
        case_num    = 0;
        case_errors = 0;
        n_pass      = 0;
        n_fail      = 0;

        repeat (10) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        compare_hex("csr_done", 32'(csr_done), 32'h0);
        compare_hex("vec_length", vec_length, 32'h0);
        compare_hex("start_element", start_element, 32'h0);
        finish_case("reset");

        fd = $fopen("tb/vec_csr_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/vec_csr_cases.txt");
            $display("Test failed");
            $finish;
        end else begin
            run_cases();
            $fclose(fd);
            $display("%0d cases run, %0d ok, %0d failed", n_pass + n_fail, n_pass, n_fail);
            if (n_fail == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: compile.f
rtl/vec_csr_pkg.sv
rtl/vec_config_unit.sv
rtl/vstart_csr_unit.sv
rtl/vec_csr_read_port.sv
rtl/vec_mem_width_decode.sv
rtl/vec_csr_regfile.sv
tb/vec_csr_regfile_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= vec_csr_regfile_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard rtl/*.sv) $(wildcard tb/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf $(OBJ_DIR)

// File: tb/vec_csr_cases.txt
# kind inst scalar1 scalar2 avl_valid width e0 e1 e2 e3 e4 (hex, unused columns are 0)
# VSET: vlmax vl vta vma   CSR: csr_out illegal start_element   WIDTH: vlmul sew eew emul e_vlmax
CSR   c21020f3 00000000 00000000 0 0 80000000 0 000 0 000
CSR   c20020f3 00000000 00000000 0 0 00000000 0 000 0 000
VSET  000572d7 0000000a 00000050 1 0 010 00a 1 0 000
CSR   c20020f3 00000000 00000000 0 0 0000000a 0 000 0 000
CSR   c21020f3 00000000 00000000 0 0 00000050 0 000 0 000
WIDTH 00000000 00000000 00000000 0 0 1 20 08 1 040
WIDTH 00000000 00000000 00000000 0 7 1 20 40 2 010
WIDTH 00000000 00000000 00000000 0 1 1 20 20 1 010
VSET  000572d7 000003e8 000000c3 1 0 200 200 1 1 000
WIDTH 00000000 00000000 00000000 0 7 8 08 40 1 008
WIDTH 00000000 00000000 00000000 0 0 8 08 08 8 200
CSR   c20020f3 00000000 00000000 0 0 00000200 0 000 0 000
VSET  000572d7 00000005 00000009 0 0 040 040 0 0 000
WIDTH 00000000 00000000 00000000 0 6 2 10 20 4 040
VSET  00007057 00000003 00000093 1 0 080 040 0 1 000
CSR   c20020f3 00000000 00000000 0 0 00000040 0 000 0 000
CSR   c21020f3 00000000 00000000 0 0 00000093 0 000 0 000
VSET  000572d7 00000010 0000002c 1 0 010 010 0 0 000
WIDTH 00000000 00000000 00000000 0 5 1 20 10 1 020
CSR   c21020f3 00000000 00000000 0 0 0000002c 0 000 0 000
CSR   008290f3 000000f0 00000000 0 0 00000000 0 0f0 0 000
CSR   0082a0f3 0000000f 00000000 0 0 000000f0 0 0ff 0 000
CSR   0082b0f3 0000003c 00000000 0 0 000000ff 0 0c3 0 000
CSR   0084d0f3 00000009 00000000 0 0 000000c3 0 009 0 000
CSR   008360f3 00000006 00000000 0 0 00000009 0 00f 0 000
CSR   0082f0f3 00000005 00000000 0 0 0000000f 0 00a 0 000
CSR   c20290f3 00000077 00000000 0 0 00000000 1 00a 0 000
CSR   c212a0f3 00000077 00000000 0 0 00000000 1 00a 0 000
CSR   300020f3 00000000 00000000 0 0 00000000 1 00a 0 000
CSR   0082c0f3 000000ff 00000000 0 0 00000000 1 00a 0 000
CSR   000572d7 00000000 00000000 0 0 00000000 0 00a 0 000
